/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbScrollFetch
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* all.f */
flashPkg.sv
fetchRequest.sv
flashToNametable.sv
spiMaster.sv
nametableRam.sv
scrollFetch.sv
spiFlashModel.sv
tbClock.sv
tbScrollFetch.sv

/* fetchRequest.sv */
module fetchRequest (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              fetchReq,
    input  logic                              fetchAttr,
    input  logic [flashPkg::FLASH_ADDR_W-1:0] flashAddrNametable,
    input  logic [flashPkg::FLASH_ADDR_W-1:0] flashAddrAttribute,
    input  logic [flashPkg::RAM_ADDR_W-1:0]   nametableRamAddrStart,
    input  logic [flashPkg::RAM_ADDR_W-1:0]   attributeRamAddrStart,
    input  logic                              seqDone,
    output logic                              fetchAck,
    output logic                              seqStart,
    output logic [flashPkg::FLASH_ADDR_W-1:0] nameFlashAddr,
    output logic [flashPkg::FLASH_ADDR_W-1:0] attrFlashAddr,
    output logic [flashPkg::RAM_ADDR_W-1:0]   nameRamStart,
    output logic [flashPkg::RAM_ADDR_W-1:0]   attrRamStart,
    output logic                              withAttr
);

    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_BUSY,
        REQ_ACKED
    } reqStateE;

    reqStateE state;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= REQ_IDLE;
            fetchAck <= 1'b0;
            seqStart <= 1'b0;
        end else begin
            seqStart <= 1'b0;
            case (state)
                REQ_IDLE: begin
                    if (fetchReq) begin
                        seqStart <= 1'b1;
                        state    <= REQ_BUSY;
                    end
                end
                REQ_BUSY: begin
                    if (seqDone) begin
                        fetchAck <= 1'b1;   // both RAMs hold the row now
                        state    <= REQ_ACKED;
                    end
                end
                REQ_ACKED: begin
                    // hold ack until the controller lets go
                    if (!fetchReq) begin
                        fetchAck <= 1'b0;
                        state    <= REQ_IDLE;
                    end
                end
                default: state <= REQ_IDLE;
            endcase
        end
    end

    // request fields are stable while fetchReq is high
    always_ff @(posedge clk) begin
        if (state == REQ_IDLE && fetchReq) begin
            nameFlashAddr <= flashAddrNametable;
            attrFlashAddr <= flashAddrAttribute;
            nameRamStart  <= nametableRamAddrStart;
            attrRamStart  <= attributeRamAddrStart;
            withAttr      <= fetchAttr;
        end
    end

endmodule

/* flashPkg.sv */
package flashPkg;

    // flash and tile-row sizes
    localparam int FLASH_ADDR_W = 24;
    localparam int RAM_ADDR_W   = 9;    // 512 words
    localparam int NAME_BYTES   = 32;   // 8 words
    localparam int ATTR_BYTES   = 8;    // 2 words

    // SPI clock divider, clk cycles per SCK half period
    localparam int SPI_HALF_DIV = 4;
    localparam int SPI_DIV_W    = $clog2(SPI_HALF_DIV);

    // flash opcodes
    typedef enum logic [7:0] {
        CMD_READ  = 8'h03,
        CMD_DUMMY = 8'hFF   // shifted out while data comes back
    } flashCmdE;

    // sequencer states, address states serve both reads
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_CMD,
        SEQ_ADDR_H,
        SEQ_ADDR_M,
        SEQ_ADDR_L,
        SEQ_DATA,
        SEQ_GAP,    // cs high between nametable and attribute reads
        SEQ_DONE
    } seqStateE;

endpackage

/* flashToNametable.sv */
module flashToNametable (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              seqStart,
    input  logic [flashPkg::FLASH_ADDR_W-1:0] nameFlashAddr,
    input  logic [flashPkg::FLASH_ADDR_W-1:0] attrFlashAddr,
    input  logic [flashPkg::RAM_ADDR_W-1:0]   nameRamStart,
    input  logic [flashPkg::RAM_ADDR_W-1:0]   attrRamStart,
    input  logic                              withAttr,
    input  logic                              byteAck,
    input  logic [7:0]                        rxByte,
    output logic                              seqDone,
    output logic                              byteReq,
    output logic [7:0]                        txByte,
    output logic                              csHold,
    output logic [3:0]                        nameWrEn,
    output logic [flashPkg::RAM_ADDR_W-1:0]   nameWrAddr,
    output logic [31:0]                       nameWrData,
    output logic [3:0]                        attrWrEn,
    output logic [flashPkg::RAM_ADDR_W-1:0]   attrWrAddr,
    output logic [31:0]                       attrWrData
);
    import flashPkg::*;

    seqStateE                state;
    logic                    phaseAttr;     // set during the attribute read
    logic [5:0]              byteCnt;       // data bytes received, reused as gap timer
    logic [FLASH_ADDR_W-1:0] curAddr;
    logic [5:0]              rowBytes;
    logic                    byteDone;
    logic [3:0]              lane;
    logic [31:0]             wrData;

    assign curAddr  = phaseAttr ? attrFlashAddr : nameFlashAddr;
    assign rowBytes = phaseAttr ? 6'(ATTR_BYTES) : 6'(NAME_BYTES);
    // previous byte acked and the engine has dropped its ack
    assign byteDone = !byteReq && !byteAck;
    // first byte of a word lands in bits 31..24
    assign lane     = 4'b1000 >> byteCnt[1:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= SEQ_IDLE;
            phaseAttr <= 1'b0;
            byteCnt   <= '0;
            byteReq   <= 1'b0;
            txByte    <= CMD_DUMMY;
            csHold    <= 1'b0;
            seqDone   <= 1'b0;
            nameWrEn  <= 4'b0;
            attrWrEn  <= 4'b0;
        end else begin
            seqDone  <= 1'b0;
            nameWrEn <= 4'b0;
            attrWrEn <= 4'b0;
            if (byteReq && byteAck) begin
                byteReq <= 1'b0;
                if (state == SEQ_DATA) begin
                    byteCnt <= byteCnt + 6'd1;
                    if (phaseAttr) begin
                        attrWrEn <= lane;
                    end else begin
                        nameWrEn <= lane;
                    end
                end
            end
            case (state)
                SEQ_IDLE: begin
                    if (seqStart) begin
                        state     <= SEQ_CMD;
                        phaseAttr <= 1'b0;
                        csHold    <= 1'b1;
                        byteReq   <= 1'b1;
                        txByte    <= CMD_READ;
                    end
                end
                SEQ_CMD: begin
                    if (byteDone) begin
                        state   <= SEQ_ADDR_H;
                        byteReq <= 1'b1;
                        txByte  <= curAddr[23:16];
                    end
                end
                SEQ_ADDR_H: begin
                    if (byteDone) begin
                        state   <= SEQ_ADDR_M;
                        byteReq <= 1'b1;
                        txByte  <= curAddr[15:8];
                    end
                end
                SEQ_ADDR_M: begin
                    if (byteDone) begin
                        state   <= SEQ_ADDR_L;
                        byteReq <= 1'b1;
                        txByte  <= curAddr[7:0];
                    end
                end
                SEQ_ADDR_L: begin
                    if (byteDone) begin
                        state   <= SEQ_DATA;
                        byteCnt <= '0;
                        byteReq <= 1'b1;
                        txByte  <= CMD_DUMMY;
                    end
                end
                SEQ_DATA: begin
                    if (byteDone) begin
                        if (byteCnt == rowBytes) begin
                            csHold  <= 1'b0;   // end of this read frame
                            byteCnt <= '0;
                            if (!phaseAttr && withAttr) begin
                                state <= SEQ_GAP;
                            end else begin
                                state <= SEQ_DONE;
                            end
                        end else begin
                            byteReq <= 1'b1;
                            txByte  <= CMD_DUMMY;
                        end
                    end
                end
                SEQ_GAP: begin
                    byteCnt <= byteCnt + 6'd1;
                    if (byteCnt == 6'd2) begin   // cs high for three cycles
                        state     <= SEQ_CMD;
                        phaseAttr <= 1'b1;
                        csHold    <= 1'b1;
                        byteReq   <= 1'b1;
                        txByte    <= CMD_READ;
                    end
                end
                SEQ_DONE: begin
                    seqDone <= 1'b1;
                    state   <= SEQ_IDLE;
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // write pointers step after lane 0 is written, wrap at 512
    always_ff @(posedge clk) begin
        if (state == SEQ_IDLE && seqStart) begin
            nameWrAddr <= nameRamStart;
            attrWrAddr <= attrRamStart;
        end else begin
            if (nameWrEn[0]) begin
                nameWrAddr <= nameWrAddr + 1'b1;
            end
            if (attrWrEn[0]) begin
                attrWrAddr <= attrWrAddr + 1'b1;
            end
        end
        if (byteReq && byteAck) begin
            wrData <= {4{rxByte}};   // byte enables pick the lane
        end
    end

    assign nameWrData = wrData;
    assign attrWrData = wrData;

endmodule

/* nametableRam.sv */
module nametableRam (
    input  logic                            clk,
    input  logic [3:0]                      wrEn,
    input  logic [flashPkg::RAM_ADDR_W-1:0] wrAddr,
    input  logic [31:0]                     wrData,
    input  logic [flashPkg::RAM_ADDR_W-1:0] rdAddr,
    output logic [31:0]                     rdData
);
    import flashPkg::*;

    logic [31:0] mem [0:(1 << RAM_ADDR_W) - 1];

    // one enable per byte lane, lane 3 is bits 31..24
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wrEn[i]) begin
                mem[wrAddr][8*i +: 8] <= wrData[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];   // one cycle latency
    end

endmodule

/* scrollFetch.sv */
module scrollFetch (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              fetchReq,
    input  logic                              fetchAttr,
    input  logic [flashPkg::FLASH_ADDR_W-1:0] flashAddrNametable,
    input  logic [flashPkg::FLASH_ADDR_W-1:0] flashAddrAttribute,
    input  logic [flashPkg::RAM_ADDR_W-1:0]   nametableRamAddrStart,
    input  logic [flashPkg::RAM_ADDR_W-1:0]   attributeRamAddrStart,
    input  logic [flashPkg::RAM_ADDR_W-1:0]   nameRdAddr,
    input  logic [flashPkg::RAM_ADDR_W-1:0]   attrRdAddr,
    input  logic                              SPI_MISO,
    output logic                              fetchAck,
    output logic [31:0]                       nameRdData,
    output logic [31:0]                       attrRdData,
    output logic                              SPI_CLK,
    output logic                              SPI_CS,
    output logic                              SPI_MOSI
);
    import flashPkg::*;

    logic                    seqStart;
    logic                    seqDone;
    logic [FLASH_ADDR_W-1:0] nameFlashAddr;
    logic [FLASH_ADDR_W-1:0] attrFlashAddr;
    logic [RAM_ADDR_W-1:0]   nameRamStart;
    logic [RAM_ADDR_W-1:0]   attrRamStart;
    logic                    withAttr;
    logic                    byteReq;
    logic                    byteAck;
    logic [7:0]              txByte;
    logic [7:0]              rxByte;
    logic                    csHold;
    logic [3:0]              nameWrEn;
    logic [RAM_ADDR_W-1:0]   nameWrAddr;
    logic [31:0]             nameWrData;
    logic [3:0]              attrWrEn;
    logic [RAM_ADDR_W-1:0]   attrWrAddr;
    logic [31:0]             attrWrData;

    fetchRequest front (
        .clk(clk), .rstn(rstn),
        .fetchReq(fetchReq), .fetchAttr(fetchAttr),
        .flashAddrNametable(flashAddrNametable), .flashAddrAttribute(flashAddrAttribute),
        .nametableRamAddrStart(nametableRamAddrStart),
        .attributeRamAddrStart(attributeRamAddrStart),
        .seqDone(seqDone), .fetchAck(fetchAck), .seqStart(seqStart),
        .nameFlashAddr(nameFlashAddr), .attrFlashAddr(attrFlashAddr),
        .nameRamStart(nameRamStart), .attrRamStart(attrRamStart), .withAttr(withAttr)
    );

    flashToNametable seq (
        .clk(clk), .rstn(rstn), .seqStart(seqStart),
        .nameFlashAddr(nameFlashAddr), .attrFlashAddr(attrFlashAddr),
        .nameRamStart(nameRamStart), .attrRamStart(attrRamStart), .withAttr(withAttr),
        .byteAck(byteAck), .rxByte(rxByte), .seqDone(seqDone),
        .byteReq(byteReq), .txByte(txByte), .csHold(csHold),
        .nameWrEn(nameWrEn), .nameWrAddr(nameWrAddr), .nameWrData(nameWrData),
        .attrWrEn(attrWrEn), .attrWrAddr(attrWrAddr), .attrWrData(attrWrData)
    );

    spiMaster spi (
        .clk(clk), .rstn(rstn),
        .byteReq(byteReq), .txByte(txByte), .csHold(csHold), .SPI_MISO(SPI_MISO),
        .byteAck(byteAck), .rxByte(rxByte),
        .SPI_CLK(SPI_CLK), .SPI_CS(SPI_CS), .SPI_MOSI(SPI_MOSI)
    );

    nametableRam nameRam (
        .clk(clk), .wrEn(nameWrEn), .wrAddr(nameWrAddr), .wrData(nameWrData),
        .rdAddr(nameRdAddr), .rdData(nameRdData)
    );

    nametableRam attrRam (
        .clk(clk), .wrEn(attrWrEn), .wrAddr(attrWrAddr), .wrData(attrWrData),
        .rdAddr(attrRdAddr), .rdData(attrRdData)
    );

endmodule

/* spiFlashModel.sv */
module spiFlashModel (
    input  logic        SPI_CLK,
    input  logic        SPI_CS,
    input  logic        SPI_MOSI,
    output logic        SPI_MISO,
    output int          frameCount,
    output int          malformedCount,
    output logic [23:0] frameAddr,
    output int          frameBytes
);
    timeunit 1ns;
    timeprecision 100ps;
    import flashPkg::*;

    int          totalBits   = 0;   // rising edges over the whole run
    int          startBits   = 0;
    int          frames      = 0;
    int          frameErrors = 0;
    int          dummyErrors = 0;
    int          lastBytes   = 0;
    bit          inFrame     = 1'b0;
    logic [7:0]  shiftIn     = 8'h00;
    logic [7:0]  opcode      = 8'h00;
    logic [23:0] addr        = '0;
    logic [23:0] lastAddr    = '0;
    logic [7:0]  outByte     = 8'h00;

    // byte at A is the xor of the three address bytes
    function automatic logic [7:0] dataAt(input logic [23:0] a);
        return a[23:16] ^ a[15:8] ^ a[7:0];
    endfunction

    always @(posedge SPI_CLK) begin : sampleMosi
        int n;
        if (SPI_CS === 1'b0) begin
            shiftIn   = {shiftIn[6:0], SPI_MOSI};
            totalBits = totalBits + 1;
            n         = totalBits - startBits;
            case (n)
                8:  opcode = shiftIn;
                16: addr[23:16] = shiftIn;
                24: addr[15:8] = shiftIn;
                32: addr[7:0] = shiftIn;
                default: begin
                    if (n > 32 && n % 8 == 0 && shiftIn != CMD_DUMMY) begin
                        dummyErrors++;
                        $display("flash model: byte %h sent during data instead of dummy", shiftIn);
                    end
                end
            endcase
        end
    end

    // next data bit goes out on the falling edge
    always @(negedge SPI_CLK) begin : driveMiso
        int n;
        n = totalBits - startBits;
        if (SPI_CS === 1'b0 && n >= 32) begin
            outByte = dataAt(addr + 24'((n - 32) / 8)) << ((n - 32) % 8);
        end
    end

    always @(SPI_CS) begin : trackFrame
        int bits;
        if (SPI_CS === 1'b0) begin
            inFrame   = 1'b1;
            startBits = totalBits;
        end else if (SPI_CS === 1'b1 && inFrame) begin
            inFrame   = 1'b0;
            bits      = totalBits - startBits;
            frames    = frames + 1;
            lastAddr  = addr;
            lastBytes = (bits - 32) / 8;
            if (opcode != CMD_READ || bits < 32 || bits % 8 != 0) begin
                frameErrors++;
                $display("flash model: malformed read frame, opcode %h and %0d bits", opcode, bits);
            end
        end
    end

    assign SPI_MISO       = outByte[7];
    assign frameCount     = frames;
    assign malformedCount = frameErrors + dummyErrors;
    assign frameAddr      = lastAddr;
    assign frameBytes     = lastBytes;

endmodule

/* spiMaster.sv */
module spiMaster (
    input  logic       clk,
    input  logic       rstn,
    input  logic       byteReq,
    input  logic [7:0] txByte,
    input  logic       csHold,
    input  logic       SPI_MISO,
    output logic       byteAck,
    output logic [7:0] rxByte,
    output logic       SPI_CLK,
    output logic       SPI_CS,
    output logic       SPI_MOSI
);
    import flashPkg::*;

    logic                 busy;
    logic [SPI_DIV_W-1:0] divCnt;
    logic [3:0]           halfCnt;   // 16 half periods per byte
    logic [7:0]           txShift;
    logic [7:0]           rxShift;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy    <= 1'b0;
            divCnt  <= '0;
            halfCnt <= '0;
            txShift <= '0;
            byteAck <= 1'b0;
            SPI_CLK <= 1'b0;
        end else begin
            if (byteAck && !byteReq) begin
                byteAck <= 1'b0;
            end
            if (!busy) begin
                if (byteReq && !byteAck) begin
                    busy    <= 1'b1;
                    // the request cycle counts toward the first half period
                    divCnt  <= SPI_DIV_W'(1);
                    halfCnt <= '0;
                    txShift <= txByte;   // bit 7 on MOSI before the first rise
                end
            end else if (divCnt == SPI_DIV_W'(SPI_HALF_DIV - 1)) begin
                divCnt  <= '0;
                SPI_CLK <= ~SPI_CLK;
                halfCnt <= halfCnt + 4'd1;
                if (!halfCnt[0]) begin
                    rxShift <= {rxShift[6:0], SPI_MISO};   // rising edge
                end else if (halfCnt == 4'd15) begin
                    busy    <= 1'b0;
                    byteAck <= 1'b1;
                end else begin
                    txShift <= {txShift[6:0], 1'b0};   // falling edge
                end
            end else begin
                divCnt <= divCnt + 1'b1;
            end
        end
    end

    assign SPI_MOSI = txShift[7];
    assign rxByte   = rxShift;
    assign SPI_CS   = ~csHold;   // low across a whole read frame

endmodule

/* tbClock.sv */
module tbClock (
    output logic clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

/* tbScrollFetch.sv */
module tbScrollFetch;
    timeunit 1ns;
    timeprecision 100ps;
    import flashPkg::*;

    localparam int BYTE_CYCLES = 16 * SPI_HALF_DIV + 4;   // byte time plus handshake
    localparam int ACK_LIMIT   = (NAME_BYTES + ATTR_BYTES + 8) * BYTE_CYCLES + 20;

    logic                    clk;
    logic                    rstn;
    logic                    fetchReq;
    logic                    fetchAttr;
    logic [FLASH_ADDR_W-1:0] flashAddrNametable;
    logic [FLASH_ADDR_W-1:0] flashAddrAttribute;
    logic [RAM_ADDR_W-1:0]   nametableRamAddrStart;
    logic [RAM_ADDR_W-1:0]   attributeRamAddrStart;
    logic [RAM_ADDR_W-1:0]   nameRdAddr;
    logic [RAM_ADDR_W-1:0]   attrRdAddr;
    logic [31:0]             nameRdData;
    logic [31:0]             attrRdData;
    logic                    fetchAck;
    logic                    SPI_MISO;
    logic                    SPI_CLK;
    logic                    SPI_CS;
    logic                    SPI_MOSI;
    int                      frameCount;
    int                      malformedCount;
    logic [FLASH_ADDR_W-1:0] frameAddr;
    int                      frameBytes;

    // expected RAM contents from the flash data rule
    logic [31:0] nameShadow [0:511];
    logic [31:0] attrShadow [0:511];
    bit          nameValid  [0:511];
    bit          attrValid  [0:511];
    int          mismatches = 0;
    int          failures   = 0;
    int          propFails  = 0;

    tbClock clkGen (.clk(clk), .rstn(rstn));
    scrollFetch dut (.*);
    spiFlashModel flash (.*);

    resetIdle: assert property (@(posedge clk) !rstn |=> !fetchAck && SPI_CS && !SPI_CLK)
        else begin
            propFails++;
            $display("MISMATCH at %0t: outputs not idle in reset", $time);
        end
    ackHeld: assert property (@(posedge clk) disable iff (!rstn) fetchAck && fetchReq |=> fetchAck)
        else begin
            propFails++;
            $display("MISMATCH at %0t: fetchAck dropped while fetchReq high", $time);
        end
    ackFall: assert property (@(posedge clk) disable iff (!rstn)
                              $fell(fetchAck) |-> !$past(fetchReq))
        else begin
            propFails++;
            $display("MISMATCH at %0t: fetchAck fell before fetchReq", $time);
        end
    csQuiet: assert property (@(posedge clk) disable iff (!rstn)
                              $fell(SPI_CS) |-> fetchReq && !fetchAck)
        else begin
            propFails++;
            $display("MISMATCH at %0t: SPI_CS fell without an open request", $time);
        end

    function automatic logic [7:0] flashByte(input logic [23:0] a);
        return a[23:16] ^ a[15:8] ^ a[7:0];
    endfunction

    // first flash byte of the word lands in bits 31..24
    function automatic logic [31:0] rowWord(input logic [23:0] base, input int w);
        return {flashByte(base + 24'(4 * w)), flashByte(base + 24'(4 * w + 1)),
                flashByte(base + 24'(4 * w + 2)), flashByte(base + 24'(4 * w + 3))};
    endfunction

    task automatic compareWord(input string what, input int idx,
                               input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("MISMATCH at %0t: %s %0d read %h, expected %h", $time, what, idx, got, exp);
        end
    endtask

    task automatic compareInt(input string what, input int got, input int exp);
        assert (got == exp) else begin
            mismatches++;
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic readWord(input bit fromAttr, input logic [8:0] a, output logic [31:0] d);
        @(negedge clk);
        nameRdAddr = a;
        attrRdAddr = a;
        @(negedge clk);   // registered read
        d = fromAttr ? attrRdData : nameRdData;
    endtask

    task automatic checkRam();
        logic [31:0] got;
        for (int i = 0; i < 512; i++) begin
            if (nameValid[i]) begin
                readWord(1'b0, 9'(i), got);
                compareWord("nametable word", i, got, nameShadow[i]);
            end
            if (attrValid[i]) begin
                readWord(1'b1, 9'(i), got);
                compareWord("attribute word", i, got, attrShadow[i]);
            end
        end
    endtask

    task automatic runFetch(input logic [23:0] nameAddr, input logic [23:0] attrAddr,
                            input logic [8:0] nameStart, input logic [8:0] attrStart,
                            input logic withAttr);
        int startFrames;
        int cycles;
        int hold;
        startFrames = frameCount;
        @(negedge clk);
        flashAddrNametable    = nameAddr;
        flashAddrAttribute    = attrAddr;
        nametableRamAddrStart = nameStart;
        attributeRamAddrStart = attrStart;
        fetchAttr             = withAttr;
        fetchReq              = 1'b1;
        cycles = 0;
        while (!fetchAck && cycles < ACK_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!fetchAck) begin
            failures++;
            $display("timeout: fetchAck did not rise within %0d cycles", ACK_LIMIT);
        end
        hold = 1 + $urandom % 16;   // controller holds the request a while
        repeat (hold) @(negedge clk);
        fetchReq = 1'b0;
        cycles = 0;
        while (fetchAck && cycles < 2) begin
            @(negedge clk);
            cycles++;
        end
        if (fetchAck) begin
            failures++;
            $display("timeout: fetchAck did not fall within 2 cycles of fetchReq");
        end
        compareInt("flash frames", frameCount - startFrames, withAttr ? 2 : 1);
        compareInt("last frame address", int'(frameAddr), int'(withAttr ? attrAddr : nameAddr));
        compareInt("last frame bytes", frameBytes, withAttr ? ATTR_BYTES : NAME_BYTES);
        for (int w = 0; w < NAME_BYTES / 4; w++) begin
            nameShadow[nameStart + 9'(w)] = rowWord(nameAddr, w);
            nameValid[nameStart + 9'(w)]  = 1'b1;
        end
        for (int w = 0; withAttr && w < ATTR_BYTES / 4; w++) begin
            attrShadow[attrStart + 9'(w)] = rowWord(attrAddr, w);
            attrValid[attrStart + 9'(w)]  = 1'b1;
        end
        repeat (4 + $urandom % 4) @(negedge clk);   // idle gap with cs high
    endtask

    initial begin
        logic [31:0] got;
        int          cycles;
        fetchReq              = 1'b0;
        fetchAttr             = 1'b0;
        flashAddrNametable    = '0;
        flashAddrAttribute    = '0;
        nametableRamAddrStart = '0;
        attributeRamAddrStart = '0;
        nameRdAddr            = '0;
        attrRdAddr            = '0;
        void'($urandom(3635));
        cycles = 0;
        while (rstn !== 1'b1 && cycles < 40) begin
            @(negedge clk);
            cycles++;
        end
        if (rstn !== 1'b1) begin
            failures++;
            $display("reset was never released");
        end
        @(negedge clk);
        assert (!fetchAck && SPI_CS && !SPI_CLK) else begin
            mismatches++;
            $display("MISMATCH at %0t: outputs not idle after reset", $time);
        end

        // combined row then a nametable row over the same attribute words
        runFetch(24'h012345, 24'h0ABCD1, 9'd16, 9'd40, 1'b1);
        checkRam();
        runFetch(24'h2004F7, 24'h33CC33, 9'd64, 9'd40, 1'b0);
        for (int i = 0; i < 2; i++) begin
            readWord(1'b1, 9'(40 + i), got);
            compareWord("untouched attribute word", 40 + i, got, attrShadow[40 + i]);
        end
        checkRam();

        // random unaligned addresses with RAM pointers wrapping past 511
        repeat (4) begin
            runFetch(24'($urandom), 24'($urandom), 9'(505 + $urandom % 7), 9'd511, 1'b1);
            checkRam();
        end

        $write("error counts: %0d mismatches, %0d assertion failures, ", mismatches, propFails);
        $display("%0d other failures, %0d malformed flash frames", failures, malformedCount);
        if (mismatches == 0 && propFails == 0 && failures == 0 && malformedCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
